/* binAddressDecoder.sv */
module binAddressDecoder (
    input  logic [histParamsPkg::tsWidth-1:0] data,
    input  histTypesPkg::histPhase_e phase,
    input  logic [histParamsPkg::pixelWidth-1:0] curPixel,
    input  logic [histParamsPkg::pixelNum*histParamsPkg::tsWidth-1:0] windowLow,
    output logic [$clog2(histParamsPkg::binNum)-1:0] binAddr,
    output logic keep
);

    import histParamsPkg::*;
    import histTypesPkg::*;

    timestamp_u ts;
    logic [tsWidth-1:0] pixWindow;
    logic [tsWidth:0] offset;           // extra msb flags data below the window
    logic [coarseWidth-1:0] bin;

    assign ts = data;
    assign pixWindow = windowLow[curPixel*tsWidth +: tsWidth];

    // fine offset inside the window of the current pixel
    assign offset = {1'b0, ts.raw} - {1'b0, pixWindow};

    always_comb begin
        if (phase == phaseCoarse) begin
            bin = ts.coarse.coarseBin;
            keep = 1'b1;
        end else begin
            bin = offset[coarseWidth-1:0];
            // only 0..15 lands in the window, everything else is dropped
            keep = (offset[tsWidth:coarseWidth] == '0);
        end
    end

    // pixel histograms sit back to back in the bin memory
    assign binAddr = {curPixel, bin};

endmodule

/* histParamsPkg.sv */
package histParamsPkg;

    // timestamp word
    localparam int tsWidth = 8;

    // coarse bin address inside one pixel histogram, 16 bins
    localparam int coarseWidth = 4;

    localparam int pixelNum = 4;
    localparam int pixelWidth = 2;          // pixel index

    // sample sequencing of one frame
    localparam int samplesPerPixel = 4;     // per pixel per acquisition
    localparam int acqNum = 2;              // acquisitions per frame

    // up to 8 hits per pixel per frame
    localparam int countWidth = 5;

    localparam int binNum = 64;             // pixelNum histograms of 16 bins

    // fine window placement, timestamp units
    localparam int halfBin = 8;
    localparam int windowMax = 240;         // last start that still fits 16 bins

endpackage

/* histTb.sv */
module histTb;
    timeunit 1ns;
    timeprecision 100ps;

    import histParamsPkg::*;
    import histTypesPkg::*;

    logic clk = 1'b0;
    logic combin_res = 1'b1;
    logic wrEn;
    logic [tsWidth-1:0] data;
    logic [pixelNum*tsWidth-1:0] result;
    logic resultValid;
    histPhase_e phase;

    logic [15:0] lfsrState;
    logic [tsWidth-1:0] coarseFrame [samplesPerPixel*pixelNum*acqNum];
    logic [tsWidth-1:0] fineFrame [samplesPerPixel*pixelNum*acqNum];
    logic [pixelNum*tsWidth-1:0] expectedQ [$];     // one entry per frame pair in flight
    int pairsSent = 0;
    int resultsChecked = 0;
    int phaseToggles = 0;
    histPhase_e lastPhase = phaseCoarse;
    longint lastWriteTime = 0;                      // drive time of the last fine sample

    partialHistogramTop UUT (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .data        (data),
        .result      (result),
        .resultValid (resultValid),
        .phase       (phase)
    );

    always #2 clk = ~clk;   // 4 ns period

    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    // one lfsr step per bit
    task automatic takeBits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | lfsrState[0];
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    task automatic stopFailed();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic checkValue(input string what, input longint got, input longint expected);
        if (got != expected) begin
            $display("error at %0d ns: %s is %0d, expected %0d", $time, what, got, expected);
            stopFailed();
        end
    endtask

    // peak bin of one pixel, arrival order, strictly greater wins
    function automatic int peakOfPixel(
            input logic [tsWidth-1:0] frame [samplesPerPixel*pixelNum*acqNum],
            input int pixel, input int low, input bit fine);
        int counts [2**coarseWidth];
        int maxCount;
        int peak;
        int bin;
        for (int b = 0; b < 2**coarseWidth; b++) counts[b] = 0;
        maxCount = 0;
        peak = 0;
        for (int i = 0; i < samplesPerPixel*pixelNum*acqNum; i++) begin
            if ((i / samplesPerPixel) % pixelNum == pixel) begin
                bin = fine ? int'(frame[i]) - low : int'(frame[i]) >> (tsWidth - coarseWidth);
                if (bin >= 0 && bin < 2**coarseWidth) begin    // outside the window is dropped
                    counts[bin]++;
                    if (counts[bin] > maxCount) begin
                        maxCount = counts[bin];
                        peak = bin;
                    end
                end
            end
        end
        return peak;
    endfunction

    function automatic logic [pixelNum*tsWidth-1:0] modelResult(
            input logic [tsWidth-1:0] cf [samplesPerPixel*pixelNum*acqNum],
            input logic [tsWidth-1:0] ff [samplesPerPixel*pixelNum*acqNum]);
        logic [pixelNum*tsWidth-1:0] res;
        int low;
        res = '0;
        for (int p = 0; p < pixelNum; p++) begin
            // window one coarse bin wide, centred on the coarse peak
            low = peakOfPixel(cf, p, 0, 1'b0) * 2**(tsWidth - coarseWidth) - halfBin;
            if (low < 0) low = 0;
            else if (low > windowMax) low = windowMax;
            res[p*tsWidth +: tsWidth] = tsWidth'(low + peakOfPixel(ff, p, low, 1'b1));
        end
        return res;
    endfunction

    // mode 0 clusters, 1 peaks in the first and last coarse bin, 2 fine samples far off
    task automatic buildPair(input int mode);
        int centers [pixelNum];
        int spread;
        int p;
        for (int q = 0; q < pixelNum; q++) takeBits(tsWidth, centers[q]);
        if (mode == 1) begin
            centers[0] = 4;
            centers[1] = 251;
            centers[2] = 6;
            centers[3] = 248;
        end
        for (int i = 0; i < samplesPerPixel*pixelNum*acqNum; i++) begin
            p = (i / samplesPerPixel) % pixelNum;
            takeBits(3, spread);
            coarseFrame[i] = tsWidth'(centers[p] + spread - 4);
            takeBits(3, spread);
            fineFrame[i] = tsWidth'(centers[p] + spread - 4 + ((mode == 2) ? 128 : 0));
        end
    endtask

    task automatic sendFrame(input logic [tsWidth-1:0] frame [samplesPerPixel*pixelNum*acqNum],
                             input bit gaps, input bit markLast);
        int idle;
        for (int i = 0; i < samplesPerPixel*pixelNum*acqNum; i++) begin
            idle = 0;
            if (gaps) takeBits(2, idle);
            repeat (idle) begin
                @(posedge clk);
                wrEn <= 1'b0;
            end
            @(posedge clk);
            wrEn <= 1'b1;
            data <= frame[i];
        end
        if (markLast) lastWriteTime = $time;
    endtask

    task automatic runPair(input int mode, input bit gaps);
        buildPair(mode);
        expectedQ.push_back(modelResult(coarseFrame, fineFrame));
        sendFrame(coarseFrame, gaps, 1'b0);
        sendFrame(fineFrame, gaps, 1'b1);
        pairsSent++;
    endtask

    always @(negedge clk) begin
        if (phase != lastPhase) phaseToggles <= phaseToggles + 1;
        lastPhase <= phase;
    end

    initial begin : compareResults
        int waited;
        logic [pixelNum*tsWidth-1:0] expected;
        waited = 0;
        forever begin
            @(negedge clk);
            if (resultValid && expectedQ.size() == 0) begin
                $display("resultValid pulsed with no frame pair in flight");
                stopFailed();
            end else if (resultValid) begin
                expected = expectedQ.pop_front();
                for (int p = 0; p < pixelNum; p++) begin
                    checkValue($sformatf("pixel %0d result", p), result[p*tsWidth +: tsWidth],
                               expected[p*tsWidth +: tsWidth]);
                end
                // two edges after the last drive, seen half a period later
                checkValue("result latency in ns", $time - lastWriteTime, 10);
                checkValue("phase toggles", phaseToggles, 2 * (resultsChecked + 1));
                checkValue("phase after a frame pair", phase, phaseCoarse);
                resultsChecked++;
                waited = 0;
            end else if (expectedQ.size() != 0) begin
                waited++;
                if (waited > 1000) begin
                    $display("no resultValid within 1000 cycles of a pending frame pair");
                    stopFailed();
                end
            end
        end
    end

    initial begin : driveStimulus
        int waited;
        wrEn = 1'b0;
        data = '0;
        combin_res = 1'b0;
        lfsrState = 16'd6930;
        repeat (8) @(posedge clk);
        combin_res <= 1'b1;
        repeat (3) @(negedge clk);
        checkValue("result after reset", result, 0);
        checkValue("phase after reset", phase, phaseCoarse);

        for (int n = 0; n < 3; n++) runPair(0, 1'b1);
        runPair(1, 1'b1);
        runPair(2, 1'b1);
        // back to back frames without idle cycles
        for (int n = 0; n < 3; n++) runPair(0, 1'b0);
        runPair(1, 1'b0);
        runPair(2, 1'b0);
        @(posedge clk);
        wrEn <= 1'b0;

        waited = 0;
        while (resultsChecked < pairsSent && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (resultsChecked == pairsSent) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("timed out waiting for the last results");
            stopFailed();
        end
    end

endmodule

/* histTb_assertions.sv */
module histTopAssertions (
    input logic clk,
    input logic combin_res,
    input logic wrEn,
    input logic resultValid,
    input histTypesPkg::histPhase_e phase
);
    timeunit 1ns;
    timeprecision 100ps;

    // result strobe is a single-cycle pulse
    resultPulseSingle: assert property (@(posedge clk) disable iff (!combin_res)
        resultValid |=> !resultValid)
        else $error("resultValid high on two consecutive cycles");

    // phase only moves on a write that closes a frame
    phaseAfterWrite: assert property (@(posedge clk) disable iff (!combin_res)
        (phase != $past(phase)) |-> $past(wrEn))
        else $error("phase changed without a write on the previous edge");

    resultQuietInReset: assert property (@(posedge clk)
        !combin_res |-> !resultValid)
        else $error("resultValid high during reset");

endmodule

bind partialHistogramTop histTopAssertions topChecks (
    .clk         (clk),
    .combin_res  (combin_res),
    .wrEn        (wrEn),
    .resultValid (resultValid),
    .phase       (phase)
);

/* histTypesPkg.sv */
package histTypesPkg;

    import histParamsPkg::*;

    // timestamp split at the coarse bin boundary
    typedef struct packed {
        logic [coarseWidth-1:0] coarseBin;
        logic [tsWidth-coarseWidth-1:0] subBin;
    } coarseView_s;

    // one word, read raw in the fine pass and split in the coarse pass
    typedef union packed {
        logic [tsWidth-1:0] raw;
        coarseView_s coarse;
    } timestamp_u;

    // which pass the shared bin memory is building
    typedef enum logic {
        phaseCoarse = 1'b0,
        phaseFine = 1'b1
    } histPhase_e;

endpackage

/* histogramAccumulator.sv */
module histogramAccumulator (
    input  logic clk,
    input  logic combin_res,
    input  logic wrEn,
    input  logic [$clog2(histParamsPkg::binNum)-1:0] binAddr,
    input  logic keep,
    output logic [histParamsPkg::pixelWidth-1:0] curPixel,
    output histTypesPkg::histPhase_e phase,
    output logic countValid,
    output logic [histParamsPkg::countWidth-1:0] binCount,
    output logic [histParamsPkg::pixelWidth-1:0] countPixel,
    output logic [histParamsPkg::coarseWidth-1:0] countBin,
    output logic frameDone,
    output histTypesPkg::histPhase_e framePhase
);

    import histParamsPkg::*;
    import histTypesPkg::*;

    logic [countWidth-1:0] binMem [binNum];
    logic [binNum-1:0] binValid;        // clear means the bin still holds an old frame
    logic [$clog2(samplesPerPixel)-1:0] sampleCnt;
    logic [$clog2(acqNum)-1:0] acqCnt;
    logic [countWidth-1:0] newCount;
    logic lastOfPixel;
    logic lastSample;

    // lazy clear, a stale bin restarts at one
    assign newCount = binValid[binAddr] ? binMem[binAddr] + 1'b1 : countWidth'(1);

    assign lastOfPixel = (sampleCnt == samplesPerPixel - 1);
    assign lastSample = lastOfPixel && (curPixel == pixelNum - 1) && (acqCnt == acqNum - 1);

    // sequencing and per-bin valid bits
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            curPixel <= '0;
            acqCnt <= '0;
            phase <= phaseCoarse;
            binValid <= '0;
            countValid <= 1'b0;
            frameDone <= 1'b0;
        end else begin
            countValid <= wrEn && keep;
            frameDone <= wrEn && lastSample;   // lines up with the last count
            if (wrEn) begin
                if (lastSample) begin
                    // whole memory becomes stale for the next pass
                    binValid <= '0;
                    phase <= (phase == phaseCoarse) ? phaseFine : phaseCoarse;
                end else if (keep) begin
                    binValid[binAddr] <= 1'b1;
                end

                if (lastOfPixel) begin
                    sampleCnt <= '0;
                    if (curPixel == pixelNum - 1) begin
                        curPixel <= '0;
                        acqCnt <= (acqCnt == acqNum - 1) ? '0 : acqCnt + 1'b1;
                    end else begin
                        curPixel <= curPixel + 1'b1;
                    end
                end else begin
                    sampleCnt <= sampleCnt + 1'b1;
                end
            end
        end
    end

    // bin memory
    always_ff @(posedge clk) begin
        if (wrEn && keep) begin
            binMem[binAddr] <= newCount;
        end
    end

    // count handed to the peak tracker
    always_ff @(posedge clk) begin
        if (wrEn) begin
            binCount <= newCount;
            countPixel <= curPixel;
            countBin <= binAddr[coarseWidth-1:0];
            framePhase <= phase;            // phase before the toggle
        end
    end

endmodule

/* list.f */
histParamsPkg.sv
histTypesPkg.sv
binAddressDecoder.sv
histogramAccumulator.sv
peakTracker.sv
partialHistogramTop.sv
histTb_assertions.sv
histTb.sv

/* partialHistogramTop.sv */
module partialHistogramTop (
    input  logic clk,
    input  logic combin_res,
    input  logic wrEn,
    input  logic [histParamsPkg::tsWidth-1:0] data,
    output logic [histParamsPkg::pixelNum*histParamsPkg::tsWidth-1:0] result,
    output logic resultValid,
    output histTypesPkg::histPhase_e phase
);

    import histParamsPkg::*;
    import histTypesPkg::*;

    // decoder to accumulator
    logic [$clog2(binNum)-1:0] binAddr;
    logic keep;
    logic [pixelWidth-1:0] curPixel;

    // accumulator to peak tracker
    logic countValid;
    logic [countWidth-1:0] binCount;
    logic [pixelWidth-1:0] countPixel;
    logic [coarseWidth-1:0] countBin;
    logic frameDone;
    histPhase_e framePhase;

    logic [pixelNum*tsWidth-1:0] windowLow;     // fed back for the fine pass

    binAddressDecoder decoder (
        .data      (data),
        .phase     (phase),
        .curPixel  (curPixel),
        .windowLow (windowLow),
        .binAddr   (binAddr),
        .keep      (keep)
    );

    histogramAccumulator accumulator (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .binAddr    (binAddr),
        .keep       (keep),
        .curPixel   (curPixel),
        .phase      (phase),
        .countValid (countValid),
        .binCount   (binCount),
        .countPixel (countPixel),
        .countBin   (countBin),
        .frameDone  (frameDone),
        .framePhase (framePhase)
    );

    peakTracker tracker (
        .clk         (clk),
        .combin_res  (combin_res),
        .countValid  (countValid),
        .binCount    (binCount),
        .countPixel  (countPixel),
        .countBin    (countBin),
        .frameDone   (frameDone),
        .framePhase  (framePhase),
        .windowLow   (windowLow),
        .result      (result),
        .resultValid (resultValid)
    );

endmodule

/* peakTracker.sv */
module peakTracker (
    input  logic clk,
    input  logic combin_res,
    input  logic countValid,
    input  logic [histParamsPkg::countWidth-1:0] binCount,
    input  logic [histParamsPkg::pixelWidth-1:0] countPixel,
    input  logic [histParamsPkg::coarseWidth-1:0] countBin,
    input  logic frameDone,
    input  histTypesPkg::histPhase_e framePhase,
    output logic [histParamsPkg::pixelNum*histParamsPkg::tsWidth-1:0] windowLow,
    output logic [histParamsPkg::pixelNum*histParamsPkg::tsWidth-1:0] result,
    output logic resultValid
);

    import histParamsPkg::*;
    import histTypesPkg::*;

    logic [countWidth-1:0] maxCount [pixelNum];
    logic [coarseWidth-1:0] peakBin [pixelNum];
    logic [countWidth-1:0] nextMax [pixelNum];
    logic [coarseWidth-1:0] nextPeak [pixelNum];
    logic [pixelNum*tsWidth-1:0] windowReg;
    logic [pixelNum*tsWidth-1:0] windowNew;     // windows from this cycle's coarse peaks

    // window start half a coarse bin below the peak bin, kept in range
    function automatic logic [tsWidth-1:0] windowStart(input logic [coarseWidth-1:0] peak);
        logic [tsWidth:0] base;
        base = {1'b0, peak, {(tsWidth - coarseWidth){1'b0}}};
        if (base < halfBin) begin
            return '0;
        end else if (base - halfBin > windowMax) begin
            return tsWidth'(windowMax);
        end else begin
            return tsWidth'(base - halfBin);
        end
    endfunction

    // running maximum including this cycle's count
    always_comb begin
        for (int p = 0; p < pixelNum; p++) begin
            nextMax[p] = maxCount[p];
            nextPeak[p] = peakBin[p];
            // strictly greater, the earlier bin keeps a tie
            if (countValid && (countPixel == pixelWidth'(p)) && (binCount > maxCount[p])) begin
                nextMax[p] = binCount;
                nextPeak[p] = countBin;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < pixelNum; p++) begin
            windowNew[p*tsWidth +: tsWidth] = windowStart(nextPeak[p]);
        end
    end

    // a fine sample right after the coarse frame end already sees its window
    assign windowLow = (frameDone && (framePhase == phaseCoarse)) ? windowNew : windowReg;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < pixelNum; p++) begin
                maxCount[p] <= '0;
                peakBin[p] <= '0;
            end
            windowReg <= '0;
            result <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= frameDone && (framePhase == phaseFine);
            for (int p = 0; p < pixelNum; p++) begin
                if (frameDone) begin
                    maxCount[p] <= '0;          // fresh maxima for the next pass
                    peakBin[p] <= '0;
                    if (framePhase == phaseCoarse) begin
                        windowReg[p*tsWidth +: tsWidth] <= windowNew[p*tsWidth +: tsWidth];
                    end else begin
                        // fine peak is an offset from the window start
                        result[p*tsWidth +: tsWidth] <=
                            windowReg[p*tsWidth +: tsWidth] + tsWidth'(nextPeak[p]);
                    end
                end else begin
                    maxCount[p] <= nextMax[p];
                    peakBin[p] <= nextPeak[p];
                end
            end
        end
    end

endmodule

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module histTb -f list.f -o histSim \
    && ./obj_dir/histSim \
    || exit 1
